//--- verilog/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REGS = 32;

    typedef logic [4:0] arch_reg_t;
    typedef logic [6:0] phys_tag_t;   // up to 128 physical regs
    typedef logic [5:0] rob_idx_t;    // up to 64 slots

    typedef enum logic [1:0] {
        ROB_EMPTY,
        ROB_WAIT,
        ROB_DONE
    } rob_state_e;

    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } dispatch_req_t;

    typedef struct packed {
        phys_tag_t ps1;
        phys_tag_t ps2;
        phys_tag_t pd;
        rob_idx_t  rob_idx;
    } rename_rsp_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } complete_t;

    // head of rob offered for retirement
    typedef struct packed {
        logic      valid;
        logic      renamed;   // entry owns a physical destination
        arch_reg_t rd;
        phys_tag_t pd;
    } retire_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_tag_t pd;
        phys_tag_t old_pd;
    } commit_t;

endpackage : rename_pkg

//--- verilog/rat_table.sv
`timescale 1ns/1ps

module rat_table #(
    parameter int NUM_PHYS = 64
) (
    input  logic                 clk,
    input  logic                 rst,

    input  rename_pkg::arch_reg_t rs1_i,
    input  rename_pkg::arch_reg_t rs2_i,
    input  rename_pkg::arch_reg_t rd_i,
    input  logic                 alloc_i,
    input  rename_pkg::phys_tag_t pd_i,

    output rename_pkg::phys_tag_t ps1_o,
    output rename_pkg::phys_tag_t ps2_o
);

    // entries only need enough bits for NUM_PHYS tags
    localparam int TAG_W = $clog2(NUM_PHYS);

    logic [TAG_W-1:0] map_q [rename_pkg::ARCH_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_q[i] <= TAG_W'(i);   // identity map
            end
        end else if (alloc_i) begin
            map_q[rd_i] <= pd_i[TAG_W-1:0];
        end
    end

    // lookup sees the map before this cycle's write
    assign ps1_o = rename_pkg::phys_tag_t'(map_q[rs1_i]);
    assign ps2_o = rename_pkg::phys_tag_t'(map_q[rs2_i]);

endmodule : rat_table

//--- verilog/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int NUM_PHYS = 64
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 pop_i,
    input  logic                 push_i,
    input  rename_pkg::phys_tag_t push_tag_i,

    output rename_pkg::phys_tag_t head_tag_o,
    output logic                 empty_o
);

    localparam int DEPTH = NUM_PHYS - rename_pkg::ARCH_REGS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rename_pkg::phys_tag_t fifo_q [DEPTH];
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [CNT_W-1:0]      count_q;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;   // full, so write side wraps onto read side
            count_q  <= CNT_W'(DEPTH);
        end else begin
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push_i) begin
                fifo_q[wr_ptr_q] <= push_tag_i;
                wr_ptr_q         <= ptr_inc(wr_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    assign head_tag_o = fifo_q[rd_ptr_q];
    assign empty_o    = (count_q == '0);

endmodule : free_list

//--- verilog/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  dispatch_valid_i,
    input  rename_pkg::arch_reg_t  rd_i,
    input  rename_pkg::phys_tag_t  free_tag_i,
    input  logic                  free_empty_i,
    input  rename_pkg::complete_t  complete_i,

    output logic                  dispatch_ready_o,
    output logic                  alloc_o,
    output rename_pkg::phys_tag_t  pd_o,
    output rename_pkg::rob_idx_t   rob_idx_o,
    output rename_pkg::retire_t    retire_o
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    rename_pkg::rob_state_e state_q   [ROB_DEPTH];
    rename_pkg::arch_reg_t  rd_q      [ROB_DEPTH];
    rename_pkg::phys_tag_t  pd_q      [ROB_DEPTH];
    logic                   renamed_q [ROB_DEPTH];

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [IDX_W:0]   count_q;

    logic             full;
    logic             need_tag;
    logic             accept;
    logic [IDX_W-1:0] cmpl_idx;

    assign full     = (count_q == (IDX_W + 1)'(ROB_DEPTH));
    assign need_tag = (rd_i != '0);   // x0 never gets a tag
    assign cmpl_idx = complete_i.rob_idx[IDX_W-1:0];

    assign dispatch_ready_o = !full && (!free_empty_i || !need_tag);
    assign accept           = dispatch_valid_i && dispatch_ready_o;
    assign alloc_o          = accept && need_tag;
    assign pd_o             = need_tag ? free_tag_i : '0;
    assign rob_idx_o        = rename_pkg::rob_idx_t'(tail_q);

    // head offered as soon as it is done
    assign retire_o.valid   = (state_q[head_q] == rename_pkg::ROB_DONE);
    assign retire_o.renamed = renamed_q[head_q];
    assign retire_o.rd      = rd_q[head_q];
    assign retire_o.pd      = pd_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= rename_pkg::ROB_EMPTY;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (complete_i.valid) begin
                state_q[cmpl_idx] <= rename_pkg::ROB_DONE;
            end
            if (accept) begin
                state_q[tail_q] <= rename_pkg::ROB_WAIT;
                tail_q          <= tail_q + 1'b1;
            end
            if (retire_o.valid) begin
                state_q[head_q] <= rename_pkg::ROB_EMPTY;
                head_q          <= head_q + 1'b1;
            end
            case ({accept, retire_o.valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q[tail_q]      <= rd_i;
            pd_q[tail_q]      <= pd_o;
            renamed_q[tail_q] <= need_tag;
        end
    end

endmodule : rob

//--- verilog/retire_map.sv
`timescale 1ns/1ps

module retire_map (
    input  logic                 clk,
    input  logic                 rst,

    input  rename_pkg::retire_t   retire_i,

    output rename_pkg::commit_t   commit_o,
    output logic                 push_o,
    output rename_pkg::phys_tag_t push_tag_o
);

    // committed arch to phys map
    rename_pkg::phys_tag_t rrat_q [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t old_pd;

    assign old_pd = rrat_q[retire_i.rd];

    assign commit_o.valid  = retire_i.valid;
    assign commit_o.rd     = retire_i.rd;
    assign commit_o.pd     = retire_i.pd;
    assign commit_o.old_pd = old_pd;

    // previous committed tag is dead once the new one commits
    assign push_o     = retire_i.valid && retire_i.renamed;
    assign push_tag_o = old_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                rrat_q[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (push_o) begin
            rrat_q[retire_i.rd] <= retire_i.pd;
        end
    end

endmodule : retire_map

//--- verilog/rename_core.sv
`timescale 1ns/1ps

module rename_core #(
    parameter int NUM_PHYS  = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     dispatch_valid_i,
    input  rename_pkg::dispatch_req_t dispatch_i,
    output logic                     dispatch_ready_o,
    output rename_pkg::rename_rsp_t   rename_o,

    input  rename_pkg::complete_t     complete_i,
    output rename_pkg::commit_t       commit_o
);

    logic                  alloc;
    rename_pkg::phys_tag_t pd;
    rename_pkg::rob_idx_t  rob_idx;
    rename_pkg::phys_tag_t ps1;
    rename_pkg::phys_tag_t ps2;

    rename_pkg::phys_tag_t free_head_tag;
    logic                  free_empty;

    rename_pkg::retire_t   retire;
    logic                  push;
    rename_pkg::phys_tag_t push_tag;

    rat_table #(
        .NUM_PHYS (NUM_PHYS)
    ) rat_table_i (
        .clk     (clk),
        .rst     (rst),
        .rs1_i   (dispatch_i.rs1),
        .rs2_i   (dispatch_i.rs2),
        .rd_i    (dispatch_i.rd),
        .alloc_i (alloc),
        .pd_i    (pd),
        .ps1_o   (ps1),
        .ps2_o   (ps2)
    );

    free_list #(
        .NUM_PHYS (NUM_PHYS)
    ) free_list_i (
        .clk        (clk),
        .rst        (rst),
        .pop_i      (alloc),
        .push_i     (push),
        .push_tag_i (push_tag),
        .head_tag_o (free_head_tag),
        .empty_o    (free_empty)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_i (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid_i),
        .rd_i             (dispatch_i.rd),
        .free_tag_i       (free_head_tag),
        .free_empty_i     (free_empty),
        .complete_i       (complete_i),
        .dispatch_ready_o (dispatch_ready_o),
        .alloc_o          (alloc),
        .pd_o             (pd),
        .rob_idx_o        (rob_idx),
        .retire_o         (retire)
    );

    retire_map retire_map_i (
        .clk        (clk),
        .rst        (rst),
        .retire_i   (retire),
        .commit_o   (commit_o),
        .push_o     (push),
        .push_tag_o (push_tag)
    );

    assign rename_o.ps1     = ps1;
    assign rename_o.ps2     = ps2;
    assign rename_o.pd      = pd;
    assign rename_o.rob_idx = rob_idx;

endmodule : rename_core

//--- dv/tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core;

    localparam int NUM_PHYS  = 38;   // free list runs dry before the rob fills
    localparam int ROB_DEPTH = 8;
    localparam int TIMEOUT   = 40;   // cycles per wait

    typedef struct packed {
        rename_pkg::arch_reg_t rd;
        rename_pkg::phys_tag_t pd;
    } inflight_t;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      dispatch_valid;
    rename_pkg::dispatch_req_t dispatch_req;
    logic                      dispatch_ready;
    rename_pkg::rename_rsp_t   rename_rsp;
    rename_pkg::complete_t     complete;
    rename_pkg::commit_t       commit;

    // reference model, updated by the compare process
    rename_pkg::phys_tag_t     model_rat  [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t     model_rrat [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t     free_q [$];
    inflight_t                 rob_model [$];
    int                        model_tail;
    int                        check_errors = 0;

    rename_pkg::rob_idx_t      pending [$];   // dispatched, not yet completed
    logic [31:0]               lcg_state;
    int                        flow_errors;
    int                        pass_count;
    int                        fail_count;
    bit                        timed_out;

    rename_core #(
        .NUM_PHYS  (NUM_PHYS),
        .ROB_DEPTH (ROB_DEPTH)
    ) rename_core_i (
        .clk              (clk),
        .rst              (rst),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_i       (dispatch_req),
        .dispatch_ready_o (dispatch_ready),
        .rename_o         (rename_rsp),
        .complete_i       (complete),
        .commit_o         (commit)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {8'h00, lcg_state[31:8]};   // low bits repeat too fast
    endfunction

    function automatic void report_error(string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
    endfunction

    function automatic rename_pkg::rename_rsp_t rename_expect(rename_pkg::dispatch_req_t req);
        rename_pkg::rename_rsp_t rsp;
        rsp.ps1     = model_rat[req.rs1];
        rsp.ps2     = model_rat[req.rs2];
        rsp.pd      = '0;
        if (req.rd != '0 && free_q.size() > 0) begin
            rsp.pd = free_q[0];   // oldest free tag
        end
        rsp.rob_idx = rename_pkg::rob_idx_t'(model_tail);
        return rsp;
    endfunction

    task automatic reset_model();
        free_q.delete();
        rob_model.delete();
        model_tail = 0;
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            model_rat[i]  = rename_pkg::phys_tag_t'(i);
            model_rrat[i] = rename_pkg::phys_tag_t'(i);
        end
        for (int t = rename_pkg::ARCH_REGS; t < NUM_PHYS; t++) begin
            free_q.push_back(rename_pkg::phys_tag_t'(t));
        end
    endtask

    always @(posedge clk) begin
        rename_pkg::rename_rsp_t exp_rsp;
        rename_pkg::commit_t     exp_commit;
        inflight_t               head;
        logic                    exp_ready;
        if (rst) begin
            reset_model();
        end else begin
            exp_ready = (rob_model.size() < ROB_DEPTH)
                        && (free_q.size() > 0 || dispatch_req.rd == '0);
            assert (dispatch_ready == exp_ready) else begin
                report_error($sformatf("dispatch_ready_o is %0b, expected %0b",
                                       dispatch_ready, exp_ready));
                check_errors++;
            end
            if (dispatch_valid && dispatch_ready) begin
                exp_rsp = rename_expect(dispatch_req);
                assert (rename_rsp == exp_rsp) else begin
                    report_error($sformatf("rename_o is %h, expected %h", rename_rsp, exp_rsp));
                    check_errors++;
                end
                if (dispatch_req.rd != '0 && free_q.size() > 0) begin
                    model_rat[dispatch_req.rd] = exp_rsp.pd;
                    void'(free_q.pop_front());
                end
                rob_model.push_back({dispatch_req.rd, exp_rsp.pd});
                model_tail = (model_tail + 1) % ROB_DEPTH;
            end
            if (commit.valid) begin
                assert (rob_model.size() > 0) else begin
                    report_error("commit_o valid with nothing in flight");
                    check_errors++;
                end
                if (rob_model.size() > 0) begin
                    head              = rob_model.pop_front();
                    exp_commit.valid  = 1'b1;
                    exp_commit.rd     = head.rd;
                    exp_commit.pd     = head.pd;
                    exp_commit.old_pd = model_rrat[head.rd];
                    assert (commit == exp_commit) else begin
                        report_error($sformatf("commit_o is %h, expected %h", commit, exp_commit));
                        check_errors++;
                    end
                    if (head.rd != '0) begin
                        free_q.push_back(model_rrat[head.rd]);
                        model_rrat[head.rd] = head.pd;
                    end
                end
            end
        end
    end

    task automatic start_cycle();
        @(negedge clk);
        dispatch_valid = 1'b0;
        complete       = '0;
    endtask

    task automatic set_dispatch(input rename_pkg::arch_reg_t rd,
                                input rename_pkg::arch_reg_t rs1,
                                input rename_pkg::arch_reg_t rs2);
        dispatch_valid   = 1'b1;
        dispatch_req.rd  = rd;
        dispatch_req.rs1 = rs1;
        dispatch_req.rs2 = rs2;
    endtask

    task automatic wait_accept();
        int n = 0;
        @(posedge clk);
        while (!dispatch_ready && !timed_out) begin
            @(negedge clk);
            complete = '0;   // completion stays a one-cycle pulse
            n++;
            if (n >= TIMEOUT) begin
                $display("timeout: dispatch was not accepted within %0d cycles", TIMEOUT);
                timed_out = 1'b1;
            end
            @(posedge clk);
        end
        if (!timed_out) begin
            pending.push_back(rename_rsp.rob_idx);
        end
    endtask

    task automatic drive_dispatch(input rename_pkg::arch_reg_t rd,
                                  input rename_pkg::arch_reg_t rs1,
                                  input rename_pkg::arch_reg_t rs2);
        start_cycle();
        set_dispatch(rd, rs1, rs2);
        wait_accept();
    endtask

    task automatic drive_random();
        logic [31:0] r;
        start_cycle();
        r = lcg_next();
        set_dispatch((free_q.size() > 0) ? r[4:0] : '0, r[9:5], r[14:10]);
        wait_accept();
    endtask

    task automatic wait_drain();
        int n = 0;
        start_cycle();
        while (rob_model.size() != 0 && !timed_out) begin
            if (n == TIMEOUT) begin
                $display("timeout: instructions still waiting to commit after %0d cycles", n);
                timed_out = 1'b1;
            end else begin
                n++;
                start_cycle();
            end
        end
    endtask

    task automatic complete_all();
        int j;
        while (pending.size() > 0) begin
            j = int'(lcg_next()) % pending.size();
            start_cycle();
            complete.valid   = 1'b1;
            complete.rob_idx = pending[j];
            pending.delete(j);
        end
        wait_drain();
    endtask

    task automatic read_reset_map();
        for (int r = 1; r < rename_pkg::ARCH_REGS; r++) begin
            drive_dispatch('0, 5'(r), 5'(rename_pkg::ARCH_REGS - r));
            if (pending.size() == ROB_DEPTH) begin
                complete_all();
            end
        end
        complete_all();
    endtask

    task automatic rename_fresh_tags();
        for (int r = 1; r <= 3; r++) begin
            drive_dispatch(5'(r), 5'(r), '0);
            drive_dispatch('0, 5'(r), 5'(r));   // reader of the new tag
        end
        complete_all();
    endtask

    task automatic shuffle_completions();
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                drive_random();
            end
            complete_all();
        end
    endtask

    task automatic fill_rob();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            drive_dispatch('0, 5'(i), 5'(i + 1));
        end
        start_cycle();
        set_dispatch('0, 5'd7, 5'd9);
        repeat (4) begin
            @(posedge clk);
            assert (!dispatch_ready) else begin
                report_error("dispatch_ready_o high with a full ROB");
                flow_errors++;
            end
        end
        @(negedge clk);
        complete.valid   = 1'b1;
        complete.rob_idx = pending.pop_front();   // oldest, so one commit follows
        wait_accept();
        complete_all();
    endtask

    task automatic exhaust_free_list();
        for (int i = 0; i < NUM_PHYS - rename_pkg::ARCH_REGS; i++) begin
            drive_dispatch(5'(i + 1), 5'(i), '0);
        end
        start_cycle();
        set_dispatch(5'd3, 5'd1, 5'd2);
        repeat (4) begin
            @(posedge clk);
            assert (!dispatch_ready) else begin
                report_error("dispatch_ready_o high for a rename with no free tag");
                flow_errors++;
            end
        end
        @(negedge clk);
        dispatch_req.rd = '0;   // x0 needs no tag
        @(posedge clk);
        assert (dispatch_ready) else begin
            report_error("dispatch_ready_o low for rd zero with room in the ROB");
            flow_errors++;
        end
        if (dispatch_ready) begin
            pending.push_back(rename_rsp.rob_idx);
        end
        complete_all();
    endtask

    task automatic random_mix_run();
        logic [31:0] r;
        int          j;
        for (int step = 0; step < 300 && !timed_out; step++) begin
            start_cycle();
            r = lcg_next();
            if (pending.size() > 0 && (r[0] || rob_model.size() == ROB_DEPTH)) begin
                j                = int'(r[23:8]) % pending.size();
                complete.valid   = 1'b1;
                complete.rob_idx = pending[j];
                pending.delete(j);
            end else if (rob_model.size() < ROB_DEPTH) begin
                set_dispatch((free_q.size() > 0) ? r[5:1] : '0, r[10:6], r[15:11]);
                wait_accept();
            end
        end
        complete_all();
    endtask

    task automatic run_test(input int num, input string name);
        int start_errors;
        start_errors = check_errors + flow_errors;
        if (!timed_out) begin
            case (num)
                1: read_reset_map();
                2: rename_fresh_tags();
                3: shuffle_completions();
                4: fill_rob();
                5: exhaust_free_list();
                default: random_mix_run();
            endcase
        end
        if (timed_out || check_errors + flow_errors != start_errors) begin
            fail_count++;
            $display("test %0d %s: failed", num, name);
        end else begin
            pass_count++;
            $display("test %0d %s: passed", num, name);
        end
    endtask

    initial begin
        lcg_state      = 32'd87627;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        complete       = '0;
        flow_errors    = 0;
        pass_count     = 0;
        fail_count     = 0;
        timed_out      = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_test(1, "rd zero reads the reset map");
        run_test(2, "renames take fresh tags in order");
        run_test(3, "random completion commits in order");
        run_test(4, "full ROB blocks dispatch");
        run_test(5, "empty free list blocks renames only");
        run_test(6, "long random run reuses freed tags");

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && check_errors + flow_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_rename_core

//--- src.f
verilog/rename_pkg.sv
verilog/rat_table.sv
verilog/free_list.sv
verilog/rob.sv
verilog/retire_map.sv
verilog/rename_core.sv
dv/tb_rename_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f src.f --top-module tb_rename_core \
    -o tb_rename_core \
    && ./obj_dir/tb_rename_core | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
exit 0
